// File: all.f
+incdir+.
xbar_pkg.sv
var_arb_chain.sv
port_arbiter.sv
req_decoder.sv
grant_collector.sv
xbar_top.sv
xbar_checker.sv
xbar_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build the crossbar testbench with verilator and run it
# the result comes from the final status line in the log

cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing -f all.f --top-module xbar_tb -Mdir obj_dir -o xbar_sim
build_status=$?
if [ $build_status -ne 0 ]; then
  echo "verilator build failed with status $build_status"
  exit 1
fi

./obj_dir/xbar_sim > "$log" 2>&1
run_status=$?
cat "$log"
if [ $run_status -ne 0 ]; then
  echo "simulation exited with status $run_status"
  exit 1
fi

if grep -qx "TESTBENCH PASSED" "$log"; then
  echo "simulation passed"
  exit 0
fi

echo "pass line not found in $log"
exit 1

// File: xbar_tb.sv
`include "xbar_cfg.svh"

// testbench top for the crossbar allocator
// clients hold each request until the grant is seen,
// all comparing happens in xbar_checker

module xbar_tb import xbar_pkg::*; ();

  localparam int NC = `XBAR_NUM_CLIENTS;
  localparam int NP = `XBAR_NUM_PORTS;

  // ---------------------------------------------------------------------
  // run length
  // ---------------------------------------------------------------------

  localparam int RESET_CYCLES    = 8;
  localparam int DIRECTED_CYCLES = 40;
  localparam int RANDOM_CYCLES   = 400;
  localparam int IDLE_CYCLES     = 20;
  localparam int RECHECK_CYCLES  = 8;
  localparam int RUN_CYCLES      = RESET_CYCLES + DIRECTED_CYCLES + RANDOM_CYCLES +
                                   IDLE_CYCLES + RECHECK_CYCLES;
  // fixed phases rounded up to the next hundred, plus a hundred for the drains
  localparam int TIMEOUT_CYCLES  = ((RUN_CYCLES + 99) / 100 + 1) * 100;

  localparam int MODE_DIRECTED = 0;
  localparam int MODE_RANDOM   = 1;
  localparam int MODE_DRAIN    = 2;

  logic        clock;
  logic        rstn;
  client_vec_t client_req;
  port_idx_t   client_dest  [NC];
  data_t       client_data  [NC];
  client_vec_t client_grant;
  logic        port_valid   [NP];
  data_t       port_data    [NP];
  client_idx_t port_src     [NP];

  int          phase;
  int          total_checks;
  int          total_errors;
  int          cycle_count = 0;
  logic [31:0] lfsr;
  client_vec_t grant_seen;

  initial clock = 1'b0;
  always #20 clock = ~clock;

  always @(posedge clock) cycle_count <= cycle_count + 1;

  // grant is combinational, so take it mid-cycle where it is settled
  always @(negedge clock) grant_seen <= client_grant;

  // galois lfsr, x^32 + x^22 + x^2 + x + 1, one step per bit
  task automatic take_bits(input int n, output logic [31:0] val);
    val = '0;
    for (int i = 0; i < n; i++) begin
      val  = {val[30:0], lfsr[0]};
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
    end
  endtask

  // ---------------------------------------------------------------------
  // one cycle of client behavior
  // ---------------------------------------------------------------------

  task automatic drive_cycle(input int mode);
    logic [31:0] r;
    logic        start;
    @(posedge clock);
    #5;
    for (int c = 0; c < NC; c++) begin
      // a grant seen at the last edge ends the held request
      if (client_req[c] && grant_seen[c]) begin
        client_req[c] = 1'b0;
      end
      if (!client_req[c] && mode != MODE_DRAIN) begin
        start = 1'b1;
        if (mode == MODE_RANDOM) begin
          take_bits(1, r);
          start = r[0];
        end
        if (start) begin
          client_req[c] = 1'b1;
          client_dest[c] = '0;
          if (mode == MODE_RANDOM) begin
            take_bits(PORT_IDX_W, r);
            client_dest[c] = port_idx_t'(r % NP);
          end
          take_bits(`XBAR_DATA_W, r);
          client_data[c] = r[`XBAR_DATA_W-1:0];
        end
      end
    end
  endtask

  // drop what is pending, then one quiet cycle so the outputs settle
  task automatic drain_clients();
    while (client_req != '0) begin
      drive_cycle(MODE_DRAIN);
    end
    drive_cycle(MODE_DRAIN);
  endtask

  // ---------------------------------------------------------------------
  // test sequence
  // ---------------------------------------------------------------------

  initial begin
    lfsr       = 32'h732d;
    rstn       = 1'b0;
    phase      = 0;
    client_req = '0;
    for (int c = 0; c < NC; c++) begin
      client_dest[c] = '0;
      client_data[c] = '0;
    end
    repeat (RESET_CYCLES) @(posedge clock);
    #5;
    rstn  = 1'b1;
    phase = 1;
    repeat (DIRECTED_CYCLES) drive_cycle(MODE_DIRECTED);
    phase = 2;
    repeat (RANDOM_CYCLES) drive_cycle(MODE_RANDOM);
    drain_clients();
    phase = 3;
    repeat (IDLE_CYCLES) drive_cycle(MODE_DRAIN);
    // first grants after idle must still follow the model priorities
    phase = 4;
    repeat (RECHECK_CYCLES) drive_cycle(MODE_RANDOM);
    drain_clients();
    phase = 5;
    @(negedge clock);
    @(negedge clock);
    #1;
    $display("all tests done: %0d checks, %0d errors", total_checks, total_errors);
    if (total_errors == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

  initial begin
    wait (cycle_count >= TIMEOUT_CYCLES);
    $display("timeout: run did not finish within %0d clock cycles", TIMEOUT_CYCLES);
    $display("TESTBENCH FAILED");
    $finish;
  end

  xbar_top DUT (
    .clock        (clock),
    .rstn         (rstn),
    .client_req   (client_req),
    .client_dest  (client_dest),
    .client_data  (client_data),
    .client_grant (client_grant),
    .port_valid   (port_valid),
    .port_data    (port_data),
    .port_src     (port_src)
  );

  xbar_checker u_checker (
    .clock        (clock),
    .rstn         (rstn),
    .phase        (phase),
    .client_req   (client_req),
    .client_dest  (client_dest),
    .client_data  (client_data),
    .client_grant (client_grant),
    .port_valid   (port_valid),
    .port_data    (port_data),
    .port_src     (port_src),
    .total_checks (total_checks),
    .total_errors (total_errors)
  );

endmodule

// File: xbar_checker.sv
`include "xbar_cfg.svh"

// checker for the crossbar allocator
// round-robin model per port, same-cycle grant compare,
// registered output compare one cycle later, one report per test

module xbar_checker import xbar_pkg::*; (
  input  logic        clock,
  input  logic        rstn,
  input  int          phase,
  input  client_vec_t client_req,
  input  port_idx_t   client_dest  [`XBAR_NUM_CLIENTS],
  input  data_t       client_data  [`XBAR_NUM_CLIENTS],
  input  client_vec_t client_grant,
  input  logic        port_valid   [`XBAR_NUM_PORTS],
  input  data_t       port_data    [`XBAR_NUM_PORTS],
  input  client_idx_t port_src     [`XBAR_NUM_PORTS],
  output int          total_checks,
  output int          total_errors
);

  localparam int NC = `XBAR_NUM_CLIENTS;
  localparam int NP = `XBAR_NUM_PORTS;

  typedef logic [NP-1:0][NC-1:0]           grant_set_t;
  typedef logic [NP-1:0][CLIENT_IDX_W-1:0] top_set_t;
  typedef logic [NC-1:0][PORT_IDX_W-1:0]   dest_set_t;

  // top[p] is the model's highest-priority client at port p
  top_set_t    top;
  grant_set_t  exp_g;
  client_vec_t exp_cg;
  dest_set_t   dest_flat;
  logic        exp_valid [NP];
  data_t       exp_data  [NP];
  client_idx_t exp_src   [NP];

  int          last_phase = 0;
  int          test_checks = 0;
  int          test_errors = 0;
  int          dir_grants = 0;
  int          dual_count = 0;
  int          recheck_grants = 0;
  int          n;
  logic        all_valid;
  client_vec_t window = '0;

  initial begin
    total_checks = 0;
    total_errors = 0;
  end

  // search from the top client upwards with wrap, first requester wins
  function automatic grant_set_t expect_grants(input client_vec_t req,
                                               input dest_set_t dest,
                                               input top_set_t tops);
    grant_set_t g;
    int         c;
    logic       found;
    g = '0;
    for (int p = 0; p < NP; p++) begin
      found = 1'b0;
      for (int i = 0; i < NC; i++) begin
        c = (int'(tops[p]) + i) % NC;
        if (!found && req[c] && int'(dest[c]) == p) begin
          g[p][c] = 1'b1;
          found = 1'b1;
        end
      end
    end
    return g;
  endfunction

  function automatic string test_name(input int ph);
    case (ph)
      0:       return "reset";
      1:       return "directed port 0";
      2:       return "random";
      3:       return "idle";
      4:       return "after idle";
      default: return "unknown";
    endcase
  endfunction

  task automatic check_value(input string name, input logic [31:0] exp_v,
                             input logic [31:0] act_v);
    test_checks++;
    total_checks++;
    if (exp_v !== act_v) begin
      test_errors++;
      total_errors++;
      $display("[ERROR] %0t %s expected %0h actual %0h", $time, name, exp_v, act_v);
    end
  endtask

  task automatic report_failure(input string msg);
    test_errors++;
    total_errors++;
    $display("%0t: %s", $time, msg);
  endtask

  task automatic finish_test(input int ph);
    if (ph == 1 && dir_grants < NC) begin
      report_failure("directed test made fewer grants than there are clients");
    end
    if (ph == 2 && dual_count == 0) begin
      report_failure("random test saw no cycle with every port valid");
    end
    if (ph == 4 && recheck_grants == 0) begin
      report_failure("no grant followed the idle test to confirm the priorities");
    end
    $display("test %0d %s: %0d checks, %0d errors", ph, test_name(ph),
             test_checks, test_errors);
    test_checks = 0;
    test_errors = 0;
  endtask

  // ---------------------------------------------------------------------
  // compare mid-cycle, where inputs and grants are settled
  // ---------------------------------------------------------------------

  always @(negedge clock) begin
    if (phase != last_phase) begin
      finish_test(last_phase);
      last_phase = phase;
    end
    if (!rstn) begin
      if (client_req == '0) begin
        check_value("client_grant", '0, 32'(client_grant));
      end
      for (int p = 0; p < NP; p++) begin
        check_value($sformatf("port_valid[%0d]", p), '0, 32'(port_valid[p]));
        check_value($sformatf("port_data[%0d]", p), '0, 32'(port_data[p]));
        check_value($sformatf("port_src[%0d]", p), '0, 32'(port_src[p]));
        exp_valid[p] = 1'b0;
        exp_data[p]  = '0;
        exp_src[p]   = '0;
      end
      top = '0;
    end else begin
      for (int c = 0; c < NC; c++) begin
        dest_flat[c] = client_dest[c];
      end
      exp_g  = expect_grants(client_req, dest_flat, top);
      exp_cg = '0;
      for (int p = 0; p < NP; p++) begin
        exp_cg = exp_cg | exp_g[p];
      end
      check_value("client_grant", 32'(exp_cg), 32'(client_grant));

      // no port of the DUT may hand out two grants in one cycle
      all_valid = 1'b1;
      for (int p = 0; p < NP; p++) begin
        n = 0;
        for (int c = 0; c < NC; c++) begin
          if (client_grant[c] && int'(client_dest[c]) == p) n++;
        end
        if (n > 1) begin
          report_failure($sformatf("port %0d granted %0d clients in one cycle", p, n));
        end
        // registered outputs belong to last cycle's grants
        check_value($sformatf("port_valid[%0d]", p), 32'(exp_valid[p]), 32'(port_valid[p]));
        if (exp_valid[p]) begin
          check_value($sformatf("port_data[%0d]", p), 32'(exp_data[p]), 32'(port_data[p]));
          check_value($sformatf("port_src[%0d]", p), 32'(exp_src[p]), 32'(port_src[p]));
        end
        if (phase == 3 && port_valid[p]) begin
          report_failure($sformatf("port %0d went valid during the idle test", p));
        end
        all_valid = all_valid & port_valid[p];
      end
      if (phase == 2 && all_valid) dual_count++;

      // grants after idle only match if the priorities held through it
      if (phase == 4 && client_grant != '0) recheck_grants++;

      // all clients aim at port 0, so each round of NC grants covers all
      if (phase == 1 && client_grant != '0) begin
        dir_grants++;
        if ((window & client_grant) != '0) begin
          report_failure("directed test granted a client twice within one round");
        end
        window = window | client_grant;
        if (window == '1) window = '0;
      end

      // winner drops to the bottom, the next client up takes the top
      for (int p = 0; p < NP; p++) begin
        exp_valid[p] = |exp_g[p];
        exp_data[p]  = '0;
        exp_src[p]   = '0;
        for (int c = 0; c < NC; c++) begin
          if (exp_g[p][c]) begin
            exp_data[p] = client_data[c];
            exp_src[p]  = client_idx_t'(c);
            top[p]      = client_idx_t'((c + 1) % NC);
          end
        end
      end
    end
  end

endmodule

// File: xbar_top.sv
`include "xbar_cfg.svh"

// crossbar switch allocator
// clients hold req, dest and data until they see their grant bit,
// grants come back in the same cycle, port outputs one cycle later

module xbar_top import xbar_pkg::*; (
  input  logic        clock,
  input  logic        rstn,

  // client side
  input  client_vec_t client_req,
  input  port_idx_t   client_dest  [`XBAR_NUM_CLIENTS],
  input  data_t       client_data  [`XBAR_NUM_CLIENTS],
  output client_vec_t client_grant,

  // output port side
  output logic        port_valid   [`XBAR_NUM_PORTS],
  output data_t       port_data    [`XBAR_NUM_PORTS],
  output client_idx_t port_src     [`XBAR_NUM_PORTS]
);

  localparam int NP = `XBAR_NUM_PORTS;

  // ---------------------------------------------------------------------
  // internal request and grant vectors, one per port
  // ---------------------------------------------------------------------

  client_vec_t port_reqs   [NP];
  client_vec_t port_grants [NP];

  // ---------------------------------------------------------------------
  // split requests by destination
  // ---------------------------------------------------------------------

  req_decoder u_decoder (
    .client_req  (client_req),
    .client_dest (client_dest),
    .port_reqs   (port_reqs)
  );

  // ---------------------------------------------------------------------
  // one round-robin arbiter per output port
  // ---------------------------------------------------------------------

  // each arbiter keeps its own priority, so ports run independently
  for (genvar p = 0; p < NP; p++) begin : g_port
    port_arbiter u_arb (
      .clock  (clock),
      .rstn   (rstn),
      .reqs   (port_reqs[p]),
      .grants (port_grants[p])
    );
  end

  // ---------------------------------------------------------------------
  // merge grants and register port outputs
  // ---------------------------------------------------------------------

  grant_collector u_collector (
    .clock        (clock),
    .rstn         (rstn),
    .port_grants  (port_grants),
    .client_data  (client_data),
    .client_grant (client_grant),
    .port_valid   (port_valid),
    .port_data    (port_data),
    .port_src     (port_src)
  );

endmodule

// File: grant_collector.sv
`include "xbar_cfg.svh"

// grant collector
// returns the grants to the clients and registers the winning data,
// source index and valid strobe on each output port

module grant_collector import xbar_pkg::*; (
  input  logic        clock,
  input  logic        rstn,
  input  client_vec_t port_grants  [`XBAR_NUM_PORTS],
  input  data_t       client_data  [`XBAR_NUM_CLIENTS],
  output client_vec_t client_grant,
  output logic        port_valid   [`XBAR_NUM_PORTS],
  output data_t       port_data    [`XBAR_NUM_PORTS],
  output client_idx_t port_src     [`XBAR_NUM_PORTS]
);

  localparam int NC = `XBAR_NUM_CLIENTS;
  localparam int NP = `XBAR_NUM_PORTS;

  // ---------------------------------------------------------------------
  // client side grants
  // ---------------------------------------------------------------------

  // a client wins at most one port, so the OR is a plain merge
  always_comb begin
    client_grant = '0;
    for (int p = 0; p < NP; p++) begin
      client_grant = client_grant | port_grants[p];
    end
  end

  // ---------------------------------------------------------------------
  // per port winner select
  // ---------------------------------------------------------------------

  logic        valid_next [NP];
  data_t       data_next  [NP];
  client_idx_t src_next   [NP];

  // OR-based one-hot encoder and AND-OR data mux
  // a zero grant vector falls out as index 0 and data 0
  always_comb begin
    for (int p = 0; p < NP; p++) begin
      valid_next[p] = |port_grants[p];
      data_next[p]  = '0;
      src_next[p]   = '0;
      for (int c = 0; c < NC; c++) begin
        if (port_grants[p][c]) begin
          data_next[p] = data_next[p] | client_data[c];
          src_next[p]  = src_next[p] | client_idx_t'(c);
        end
      end
    end
  end

  // ---------------------------------------------------------------------
  // output registers
  // ---------------------------------------------------------------------

  // one cycle after the grant, valid is a single-cycle strobe
  // with no back-pressure from the port side
  always_ff @(posedge clock or negedge rstn) begin
    if (!rstn) begin
      for (int p = 0; p < NP; p++) begin
        port_valid[p] <= 1'b0;
        port_data[p]  <= '0;
        port_src[p]   <= '0;
      end
    end else begin
      for (int p = 0; p < NP; p++) begin
        port_valid[p] <= valid_next[p];
        port_data[p]  <= data_next[p];
        port_src[p]   <= src_next[p];
      end
    end
  end

endmodule

// File: req_decoder.sv
`include "xbar_cfg.svh"

// request decoder
// splits the client requests into one request vector per output port,
// using the destination each client presents with its request

module req_decoder import xbar_pkg::*; (
  input  client_vec_t client_req,
  input  port_idx_t   client_dest [`XBAR_NUM_CLIENTS],
  output client_vec_t port_reqs   [`XBAR_NUM_PORTS]
);

  localparam int NC = `XBAR_NUM_CLIENTS;
  localparam int NP = `XBAR_NUM_PORTS;

  // ---------------------------------------------------------------------
  // destination match
  // ---------------------------------------------------------------------

  // dest_hit[p][c] set when client c names port p, whether or not
  // the client is requesting right now
  client_vec_t dest_hit [NP];

  always_comb begin
    for (int p = 0; p < NP; p++) begin
      for (int c = 0; c < NC; c++) begin
        dest_hit[p][c] = (client_dest[c] == port_idx_t'(p));
      end
    end
  end

  // ---------------------------------------------------------------------
  // gate with the request level
  // ---------------------------------------------------------------------

  // a client names one destination only, so each client bit is set
  // in at most one port vector
  always_comb begin
    for (int p = 0; p < NP; p++) begin
      port_reqs[p] = dest_hit[p] & client_req;
    end
  end

endmodule

// File: port_arbiter.sv
`include "xbar_cfg.svh"

// round-robin arbiter for a single output port
// the winner of a cycle drops to the lowest priority for the next one,
// which gives strong fairness among clients aiming at this port

module port_arbiter import xbar_pkg::*; (
  input  logic        clock,
  input  logic        rstn,
  input  client_vec_t reqs,
  output client_vec_t grants
);

  localparam int N = `XBAR_NUM_CLIENTS;

  // ---------------------------------------------------------------------
  // priority state
  // ---------------------------------------------------------------------

  // one-hot, bit set marks the client with the highest priority
  client_vec_t prio;

  // only move the pointer when somebody actually won
  logic        prio_en;
  client_vec_t prio_next;

  assign prio_en = |grants;

  // grant rotated left by one: the client just after the winner
  // goes to the top, the winner itself to the bottom
  assign prio_next = client_vec_t'((grants << 1) | (grants >> (N-1)));

  always_ff @(posedge clock or negedge rstn) begin
    if (!rstn) begin
      // client 0 starts with the highest priority
      prio <= client_vec_t'(1);
    end else if (prio_en) begin
      prio <= prio_next;
    end
  end

  // ---------------------------------------------------------------------
  // arbitration
  // ---------------------------------------------------------------------

  // grant is combinational, same cycle as the request
  var_arb_chain u_chain (
    .prio   (prio),
    .reqs   (reqs),
    .grants (grants)
  );

endmodule

// File: var_arb_chain.sv
`include "xbar_cfg.svh"

// variable-priority arbiter
// the one-hot prio input marks the client with the highest priority,
// priority then falls off in increasing index order and wraps around

module var_arb_chain import xbar_pkg::*; (
  input  client_vec_t prio,
  input  client_vec_t reqs,
  output client_vec_t grants
);

  localparam int N = `XBAR_NUM_CLIENTS;

  // ---------------------------------------------------------------------
  // replicated kill chain
  // ---------------------------------------------------------------------

  // a circular chain would be a combinational loop, so the requesters
  // are laid out twice and the chain runs straight through both copies
  logic [2*N-1:0] kills;
  logic [2*N-1:0] prio_int;
  logic [2*N-1:0] reqs_int;
  logic [2*N-1:0] grants_int;

  // everything ahead of the priority position starts out killed
  assign kills[0] = 1'b1;

  // priority marker only in the lower copy, the upper copy
  // picks up the requesters that wrap around
  assign prio_int = {{N{1'b0}}, prio};
  assign reqs_int = {reqs, reqs};

  for (genvar i = 0; i < 2*N; i++) begin : g_chain
    // the highest-priority slot ignores the incoming kill
    assign grants_int[i] = prio_int[i] ? reqs_int[i]
                                       : (!kills[i] && reqs_int[i]);

    // kill passes on once any earlier slot in the chain has won
    // last slot has nobody after it, so no kill is formed there
    if (i < 2*N-1) begin : g_kill
      assign kills[i+1] = prio_int[i] ? grants_int[i]
                                      : (kills[i] || grants_int[i]);
    end
  end

  // ---------------------------------------------------------------------
  // fold the two copies back together
  // ---------------------------------------------------------------------

  // at most one slot over both halves wins, so the OR stays one-hot
  assign grants = grants_int[N-1:0] | grants_int[2*N-1:N];

endmodule

// File: xbar_pkg.sv
`include "xbar_cfg.svh"

package xbar_pkg;

  // ---------------------------------------------------------------------
  // index widths
  // ---------------------------------------------------------------------

  // a single port or client still needs one bit to carry its index
  localparam int PORT_IDX_W =
    (`XBAR_NUM_PORTS > 1) ? $clog2(`XBAR_NUM_PORTS) : 1;
  localparam int CLIENT_IDX_W =
    (`XBAR_NUM_CLIENTS > 1) ? $clog2(`XBAR_NUM_CLIENTS) : 1;

  // ---------------------------------------------------------------------
  // shared vector types
  // ---------------------------------------------------------------------

  // one bit per client: requests, grants and one-hot priority
  typedef logic [`XBAR_NUM_CLIENTS-1:0] client_vec_t;

  // destination port number named by a client
  typedef logic [PORT_IDX_W-1:0] port_idx_t;

  // source client number reported on an output port
  typedef logic [CLIENT_IDX_W-1:0] client_idx_t;

  // payload word carried from a client to a port
  typedef logic [`XBAR_DATA_W-1:0] data_t;

endpackage

// File: xbar_cfg.svh
`ifndef XBAR_CFG_SVH
`define XBAR_CFG_SVH

// ---------------------------------------------------------------------
// crossbar sizing
// ---------------------------------------------------------------------

// number of requesting clients, one bit each in every request vector
`define XBAR_NUM_CLIENTS 4

// number of output ports, one round-robin arbiter per port
`define XBAR_NUM_PORTS 2

// width of the data word a client presents with its request
`define XBAR_DATA_W 16

`endif
